// ==== discharge_pkg.sv ====
`default_nettype none

package discharge_pkg;

	localparam int pwm_cnt_width = 16; // period counter and thresholds.
	localparam int frac_width    = 16; // fraction bits of the ramp value.
	localparam int hold_width    = 32; // pre and keep period counts.
	localparam int tag_width     = 8;

	// one queued discharge profile.
	typedef struct packed {
		logic [tag_width-1:0]                tag;
		logic [pwm_cnt_width-1:0]            denominator; // period in cycles, at least 3.
		logic [pwm_cnt_width-1:0]            numerator0;  // start threshold.
		logic [pwm_cnt_width-1:0]            numerator1;  // end threshold.
		logic [hold_width-1:0]               number0;     // pre periods.
		logic [hold_width-1:0]               number1;     // keep periods.
		logic [pwm_cnt_width+frac_width-1:0] inc0;        // ramp step, 16.16.
	} discharge_profile_t;

	// one record per finished profile.
	typedef struct packed {
		logic [tag_width-1:0]  tag;
		logic [hold_width-1:0] periods;
		logic [hold_width-1:0] active_cycles;
	} discharge_status_t;

	typedef enum logic [1:0] {
		ramp_idle,
		ramp_pre,
		ramp_inc,
		ramp_keep
	} ramp_state_t;

endpackage

`default_nettype wire

// ==== discharge_cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module discharge_cmd_queue import discharge_pkg::*; #(
	parameter int queue_depth = 2
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               cmd_valid,
	input  discharge_profile_t cmd,
	output logic               cmd_credit,
	output logic               profile_avail,
	output discharge_profile_t profile,
	input  logic               profile_take
);

	localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_width = $clog2(queue_depth + 1);

	discharge_profile_t   mem [queue_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [cnt_width-1:0] count; // entries held.

	// wraps at the queue depth, which need not be a power of two.
	function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
		logic [ptr_width-1:0] next;
		if (ptr == ptr_width'(queue_depth - 1))
			next = '0;
		else
			next = ptr + 1'b1;
		return next;
	endfunction

	always_ff @(posedge clk) begin
		if (cmd_valid)
			mem[wr_ptr] <= cmd;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (cmd_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (profile_take)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + cnt_width'(cmd_valid) - cnt_width'(profile_take);
		end
	end

	// one credit back for every entry that leaves.
	always_ff @(posedge clk) begin
		if (!resetn)
			cmd_credit <= 1'b0;
		else
			cmd_credit <= profile_take;
	end

	assign profile_avail = (count != '0);
	assign profile       = mem[rd_ptr]; // head entry.

	// sender must hold a credit, so the queue is never written full.
	a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
		cmd_valid |-> count != cnt_width'(queue_depth))
		else $error("cmd_valid without a command credit");

	a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
		profile_take |-> count != '0)
		else $error("profile_take on an empty queue");

endmodule

`default_nettype wire

// ==== discharge_ramp_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module discharge_ramp_ctl import discharge_pkg::*; #(
	parameter logic default_level = 1'b0
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 profile_avail,
	input  discharge_profile_t   profile,
	output logic                 profile_take,
	input  logic                 status_free,
	output logic                 drive_next,
	output logic                 period_end,
	output logic                 profile_done,
	output logic [tag_width-1:0] busy_tag
);

	localparam int num_width = pwm_cnt_width + frac_width;

	ramp_state_t              state;
	discharge_profile_t       prof;          // profile being played.
	logic [pwm_cnt_width-1:0] cnt;           // counts down to zero each period.
	logic                     eop_p1;        // counter at one.
	logic                     eop;           // counter at zero.
	logic                     finishing;     // last keep period running.
	logic [num_width-1:0]     numerator_ext; // 16.16 threshold.
	logic [pwm_cnt_width-1:0] numerator;
	logic [hold_width-1:0]    hold_cnt;      // periods left in pre or keep.

	assign numerator    = numerator_ext[num_width-1:frac_width];
	assign busy_tag     = prof.tag;
	assign profile_take = (state == ramp_idle) && profile_avail && status_free;

	always_ff @(posedge clk) begin
		if (profile_take)
			prof <= profile;
	end

	// period counter, parked at zero while idle.
	always_ff @(posedge clk) begin
		if (!resetn)
			cnt <= '0;
		else if (state == ramp_idle || profile_done)
			cnt <= '0;
		else if (cnt == '0)
			cnt <= prof.denominator - 1'b1;
		else
			cnt <= cnt - 1'b1;
	end

	// period end seen one cycle ahead so the next threshold is ready at zero.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			eop_p1       <= 1'b0;
			eop          <= 1'b0;
			period_end   <= 1'b0;
			profile_done <= 1'b0;
		end else begin
			eop_p1       <= (state != ramp_idle) && !finishing && (cnt == pwm_cnt_width'(2));
			eop          <= eop_p1;
			period_end   <= eop;
			profile_done <= eop && finishing;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= ramp_idle;
			finishing <= 1'b0;
		end else if (profile_take) begin
			state <= ramp_pre;
		end else if (profile_done) begin
			state     <= ramp_idle;
			finishing <= 1'b0;
		end else if (eop_p1) begin
			case (state)
				ramp_pre: begin
					if (hold_cnt <= 1)
						state <= ramp_inc;
				end
				ramp_inc: begin
					if (numerator <= prof.numerator1)
						state <= ramp_keep;
				end
				ramp_keep: begin
					if (hold_cnt <= 1)
						finishing <= 1'b1; // no drive after this period.
				end
				default: begin
					state <= ramp_idle;
				end
			endcase
		end
	end

	// threshold and hold count for the next period.
	always_ff @(posedge clk) begin
		if (profile_take) begin
			numerator_ext <= {profile.numerator0, {frac_width{1'b0}}};
			hold_cnt      <= profile.number0;
		end else if (eop_p1) begin
			case (state)
				ramp_pre: begin
					hold_cnt <= hold_cnt - 1'b1;
				end
				ramp_inc: begin
					if (numerator <= prof.numerator1) begin
						numerator_ext <= {prof.numerator1, {frac_width{1'b0}}};
						hold_cnt      <= prof.number1;
					end else if (numerator_ext > prof.inc0) begin
						numerator_ext <= numerator_ext - prof.inc0;
					end else begin
						numerator_ext <= '0; // clamp, ends the ramp next period.
					end
				end
				ramp_keep: begin
					hold_cnt <= hold_cnt - 1'b1;
				end
				default: begin
					hold_cnt <= hold_cnt;
				end
			endcase
		end
	end

	// active from zero until the counter meets the threshold.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			drive_next <= default_level;
		end else if (state == ramp_idle) begin
			drive_next <= default_level;
		end else if (cnt == '0) begin
			if (!finishing && numerator < prof.denominator)
				drive_next <= ~default_level;
			else
				drive_next <= default_level;
		end else if (cnt == numerator) begin
			drive_next <= default_level;
		end
	end

	a_min_period: assert property (@(posedge clk) disable iff (!resetn)
		profile_take |-> profile.denominator >= pwm_cnt_width'(3))
		else $error("profile loaded with denominator below 3");

	// the flag chain must not run past the end of a profile.
	a_busy_on_period: assert property (@(posedge clk) disable iff (!resetn)
		period_end |-> state != ramp_idle)
		else $error("period_end while idle");

endmodule

`default_nettype wire

// ==== discharge_gate_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module discharge_gate_out import discharge_pkg::*; #(
	parameter logic default_level  = 1'b0,
	parameter int   status_credits = 2
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 drive_next,
	input  logic                 period_end,
	input  logic                 profile_done,
	input  logic [tag_width-1:0] busy_tag,
	output logic                 gate,
	output logic                 status_free,
	output logic                 status_valid,
	output discharge_status_t    status,
	input  logic                 status_credit
);

	localparam int credit_width = $clog2(status_credits + 1);

	logic [credit_width-1:0] credit_cnt;
	logic [hold_width-1:0]   period_cnt;
	logic [hold_width-1:0]   active_cnt;
	logic                    gate_on;
	logic                    pending;      // record waiting for a credit.
	logic                    credit_avail;
	logic                    record_ready;
	logic                    send;

	assign gate_on      = (gate != default_level);
	assign credit_avail = (credit_cnt != '0) || status_credit; // a returning credit counts.
	assign record_ready = profile_done || pending;
	assign send         = record_ready && credit_avail;
	assign status_free  = !pending;

	always_ff @(posedge clk) begin
		if (!resetn)
			gate <= default_level;
		else
			gate <= drive_next;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			period_cnt <= '0;
			active_cnt <= '0;
		end else if (profile_done) begin
			period_cnt <= '0;
			active_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + hold_width'(period_end);
			active_cnt <= active_cnt + hold_width'(gate_on);
		end
	end

	// final period and last gate cycle land together with profile_done.
	always_ff @(posedge clk) begin
		if (profile_done) begin
			status.tag           <= busy_tag;
			status.periods       <= period_cnt + 1'b1;
			status.active_cycles <= active_cnt + hold_width'(gate_on);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pending      <= 1'b0;
			status_valid <= 1'b0;
			credit_cnt   <= credit_width'(status_credits);
		end else begin
			pending      <= record_ready && !credit_avail;
			status_valid <= send;
			credit_cnt   <= credit_cnt + credit_width'(status_credit) - credit_width'(send);
		end
	end

	// the receiver never returns more than it was given.
	a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
		credit_cnt <= credit_width'(status_credits))
		else $error("status credit count above %0d", status_credits);

	// the credit spent on a record is still out while the record goes.
	a_valid_credit: assert property (@(posedge clk) disable iff (!resetn)
		status_valid |-> credit_cnt < credit_width'(status_credits))
		else $error("status_valid sent without a credit");

endmodule

`default_nettype wire

// ==== discharge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module discharge_top import discharge_pkg::*; #(
	parameter int   queue_depth    = 2,
	parameter int   status_credits = 2,
	parameter logic default_level  = 1'b0
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               cmd_valid,
	input  discharge_profile_t cmd,
	output logic               cmd_credit,
	output logic               gate,
	output logic               status_valid,
	output discharge_status_t  status,
	input  logic               status_credit
);

	logic                 profile_avail;
	discharge_profile_t   profile;
	logic                 profile_take;
	logic                 status_free;
	logic                 drive_next;
	logic                 period_end;
	logic                 profile_done;
	logic [tag_width-1:0] busy_tag;

	discharge_cmd_queue #(
		.queue_depth(queue_depth)
	) queue_i (
		.clk          (clk),
		.resetn       (resetn),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_credit   (cmd_credit),
		.profile_avail(profile_avail),
		.profile      (profile),
		.profile_take (profile_take)
	);

	discharge_ramp_ctl #(
		.default_level(default_level)
	) ramp_ctl_i (
		.clk          (clk),
		.resetn       (resetn),
		.profile_avail(profile_avail),
		.profile      (profile),
		.profile_take (profile_take),
		.status_free  (status_free),
		.drive_next   (drive_next),
		.period_end   (period_end),
		.profile_done (profile_done),
		.busy_tag     (busy_tag)
	);

	discharge_gate_out #(
		.default_level (default_level),
		.status_credits(status_credits)
	) gate_out_i (
		.clk          (clk),
		.resetn       (resetn),
		.drive_next   (drive_next),
		.period_end   (period_end),
		.profile_done (profile_done),
		.busy_tag     (busy_tag),
		.gate         (gate),
		.status_free  (status_free),
		.status_valid (status_valid),
		.status       (status),
		.status_credit(status_credit)
	);

endmodule

`default_nettype wire

// ==== tb_discharge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_discharge import discharge_pkg::*; ();

	localparam int   queue_depth    = 2;
	localparam int   status_credits = 2;
	localparam logic default_level  = 1'b0;
	localparam int   num_vectors    = 10;
	localparam int   fields         = 8; // words per vector line.
	localparam int   reset_cycles   = 10;

	logic               clk;
	logic               resetn        = 1'b0;
	logic               cmd_valid     = 1'b0;
	discharge_profile_t cmd           = '0;
	logic               cmd_credit;
	logic               gate;
	logic               status_valid;
	discharge_status_t  status;
	logic               status_credit = 1'b0;

	logic [31:0]        vec_mem [num_vectors*fields];
	discharge_profile_t profiles [num_vectors];
	int                 delays [num_vectors];
	logic [31:0]        exp_periods [num_vectors];
	logic [31:0]        exp_active [num_vectors];
	discharge_status_t  expected_q [$];
	int                 credit_due_q [$]; // cycles at which status credits go back.

	int          cycle            = 0;
	int          post_reset       = 0;
	int          timeout_limit    = 1000;
	int          max_delay        = 0;
	int          cmd_credits      = queue_depth;
	int          sent             = 0;
	int          credit_pulses    = 0;
	int          cmd_errors       = 0;
	int          reset_edges      = 0;
	int          dut_sends        = 0;
	int          credits_returned = 0;
	int          records_done     = 0;
	int          passed_count     = 0;
	int          failed_count     = 0;
	int          rec_errors       = 0;
	logic [31:0] gate_count       = '0; // gate-active cycles since the last record.

	discharge_top #(
		.queue_depth   (queue_depth),
		.status_credits(status_credits),
		.default_level (default_level)
	) discharge_top_i (
		.clk          (clk),
		.resetn       (resetn),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_credit   (cmd_credit),
		.gate         (gate),
		.status_valid (status_valid),
		.status       (status),
		.status_credit(status_credit)
	);

	function automatic logic [31:0] period_active_cycles(input logic [15:0] den,
		input logic [15:0] num);
		logic [31:0] result;
		if (num < den)
			result = 32'(den - num);
		else
			result = '0; // threshold at or past the period, no pulse.
		return result;
	endfunction

	// pre, ramp and keep periods of one profile.
	task automatic model_profile(input discharge_profile_t p, output logic [31:0] periods,
		output logic [31:0] active);
		logic [31:0] pre_n;
		logic [31:0] keep_n;
		logic [31:0] ramp_n;
		logic [31:0] total;
		logic [31:0] value; // 16.16 threshold.
		logic        reached;
		pre_n   = (p.number0 == '0) ? 32'd1 : p.number0;
		keep_n  = (p.number1 == '0) ? 32'd1 : p.number1;
		total   = pre_n * period_active_cycles(p.denominator, p.numerator0);
		value   = {p.numerator0, 16'h0000};
		ramp_n  = '0;
		reached = 1'b0;
		while (!reached && ramp_n < 32'd100000) begin
			ramp_n  = ramp_n + 1;
			total   = total + period_active_cycles(p.denominator, value[31:16]);
			reached = (value[31:16] <= p.numerator1); // this period still counts.
			if (!reached)
				value = (value > p.inc0) ? value - p.inc0 : '0;
		end
		periods = pre_n + ramp_n + keep_n;
		active  = total + keep_n * period_active_cycles(p.denominator, p.numerator1);
	endtask

	task automatic check_idle_outputs(input string phase);
		assert (gate == default_level) else begin
			$display("error %0t: gate not at its idle level %s", $time, phase);
			rec_errors++;
		end
		assert (!status_valid) else begin
			$display("error %0t: status_valid high %s", $time, phase);
			rec_errors++;
		end
		assert (!cmd_credit) else begin
			$display("error %0t: cmd_credit high %s", $time, phase);
			rec_errors++;
		end
	endtask

	task automatic check_record(input discharge_status_t exp_rec, input discharge_status_t got,
		input logic [31:0] port_active, output logic ok);
		ok = 1'b1;
		assert (got.tag == exp_rec.tag) else begin
			$display("error %0t: tag %0h, expected %0h", $time, got.tag, exp_rec.tag);
			ok = 1'b0;
		end
		assert (got.periods == exp_rec.periods) else begin
			$display("error %0t: periods %0d, expected %0d", $time, got.periods,
				exp_rec.periods);
			ok = 1'b0;
		end
		assert (got.active_cycles == exp_rec.active_cycles) else begin
			$display("error %0t: active_cycles %0d, expected %0d", $time, got.active_cycles,
				exp_rec.active_cycles);
			ok = 1'b0;
		end
		assert (port_active == exp_rec.active_cycles) else begin
			$display("error %0t: %0d gate-active cycles at the port, expected %0d", $time,
				port_active, exp_rec.active_cycles);
			ok = 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (resetn)
			post_reset <= post_reset + 1;
		if (cycle >= timeout_limit) begin
			$display("timeout after %0d cycles with %0d of %0d status records received",
				cycle, records_done, num_vectors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// command sender, spends one credit per profile.
	always @(posedge clk) begin
		discharge_status_t exp_rec;
		if (resetn) begin
			if (cmd_credit) begin
				credit_pulses = credit_pulses + 1;
				cmd_credits   = cmd_credits + 1;
				assert (credit_pulses <= sent) else begin
					$display("error %0t: cmd_credit pulse %0d after only %0d commands", $time,
						credit_pulses, sent);
					cmd_errors++;
				end
			end
			if (post_reset >= 3 && sent < num_vectors && cmd_credits > 0) begin
				exp_rec.tag           = profiles[sent].tag;
				exp_rec.periods       = exp_periods[sent];
				exp_rec.active_cycles = exp_active[sent];
				expected_q.push_back(exp_rec);
				cmd_valid   <= 1'b1;
				cmd         <= profiles[sent];
				cmd_credits = cmd_credits - 1;
				sent        = sent + 1;
			end else begin
				cmd_valid <= 1'b0;
			end
		end
	end

	// status receiver and gate monitor.
	always @(posedge clk) begin
		discharge_status_t exp_rec;
		logic              ok;
		if (!resetn) begin
			reset_edges = reset_edges + 1;
			if (reset_edges > 1)
				check_idle_outputs("during reset");
		end else if (post_reset < 3) begin
			check_idle_outputs("just after reset");
		end
		if (resetn) begin
			if (status_valid) begin
				dut_sends = dut_sends + 1;
				assert (dut_sends <= status_credits + credits_returned) else begin
					$display("error %0t: status_valid without a status credit", $time);
					rec_errors++;
				end
				if (expected_q.size() == 0) begin
					$display("a status record arrived with no profile outstanding");
					rec_errors++;
				end else begin
					exp_rec = expected_q.pop_front();
					check_record(exp_rec, status, gate_count, ok);
					if (ok)
						passed_count++;
					else
						failed_count++;
					$display("profile %0d tag %02h: %0d periods, %0d active cycles, %s",
						records_done, status.tag, status.periods, status.active_cycles,
						ok ? "ok" : "mismatch");
					credit_due_q.push_back(cycle + delays[records_done]);
				end
				records_done <= records_done + 1;
				gate_count = '0;
			end
			if (status_credit)
				credits_returned++;
			if (gate != default_level)
				gate_count = gate_count + 1;
			if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
				status_credit <= 1'b1;
				void'(credit_due_q.pop_front());
			end else begin
				status_credit <= 1'b0;
			end
		end
	end

	initial begin
		int                 idx;
		int                 base;
		int                 sum_cycles;
		int                 final_errors;
		discharge_profile_t p;
		$readmemh("discharge_vectors.txt", vec_mem);
		sum_cycles   = 0;
		final_errors = 0;
		for (idx = 0; idx < num_vectors; idx++) begin
			base          = idx * fields;
			p.tag         = vec_mem[base][7:0];
			p.denominator = vec_mem[base + 1][15:0];
			p.numerator0  = vec_mem[base + 2][15:0];
			p.numerator1  = vec_mem[base + 3][15:0];
			p.number0     = vec_mem[base + 4];
			p.number1     = vec_mem[base + 5];
			p.inc0        = vec_mem[base + 6];
			profiles[idx] = p;
			delays[idx]   = int'(vec_mem[base + 7]);
			model_profile(p, exp_periods[idx], exp_active[idx]);
			sum_cycles = sum_cycles + int'(exp_periods[idx]) * int'(p.denominator) + delays[idx];
			if (delays[idx] > max_delay)
				max_delay = delays[idx];
		end
		timeout_limit = 2 * sum_cycles + 1000;
		repeat (reset_cycles) @(posedge clk);
		resetn <= 1'b1;
		while (records_done < num_vectors)
			@(posedge clk);
		repeat (max_delay + 10) @(posedge clk); // let the last credits come back.
		assert (sent == num_vectors) else begin
			$display("only %0d of %0d profiles were sent", sent, num_vectors);
			final_errors++;
		end
		assert (credit_pulses == num_vectors) else begin
			$display("error %0t: %0d cmd_credit pulses for %0d profiles", $time,
				credit_pulses, num_vectors);
			final_errors++;
		end
		assert (cmd_credits == queue_depth) else begin
			$display("error %0t: %0d command credits held at the end, expected %0d", $time,
				cmd_credits, queue_depth);
			final_errors++;
		end
		assert (expected_q.size() == 0) else begin
			$display("%0d expected status records never arrived", expected_q.size());
			final_errors++;
		end
		final_errors = final_errors + cmd_errors + rec_errors;
		$display("%0d profiles, %0d passed, %0d failed, %0d other errors", num_vectors,
			passed_count, failed_count, final_errors);
		if (final_errors == 0 && failed_count == 0 && passed_count == num_vectors)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== discharge_vectors.txt ====
// tag denominator numerator0 numerator1 number0 number1 inc0(16.16) credit_delay, all hex.
// credit_delay is the wait in cycles before the status credit for that record goes back.
01 0020 0018 0008 00000002 00000002 00040000 00000000
02 0010 0010 0004 00000003 00000001 00030000 00000000
03 0003 0002 0000 00000000 00000000 00008000 00000002
04 0040 0030 0030 00000001 00000003 00010000 00000005
05 0025 0020 0000 00000001 00000002 00058000 0000012c
06 0008 0007 0001 00000002 00000002 00012000 0000012c
07 0010 000c 0002 00000001 00000001 00040000 00000032
08 0014 0014 0014 00000001 00000001 00010000 0000000a
09 0100 0080 0010 00000001 00000001 00200000 00000000
0a 0005 0003 0001 00000002 00000002 00006000 00000001

// ==== verilog.f ====
discharge_pkg.sv
discharge_cmd_queue.sv
discharge_ramp_ctl.sv
discharge_gate_out.sv
discharge_top.sv
tb_discharge.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       := tb_discharge
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
VECTORS   := discharge_vectors.txt
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
